//--- project.f
rtl/mbox_pkg.sv
rtl/mbox_access_decode.sv
rtl/mbox_lock_regs.sv
rtl/mbox_sram_zeroize.sv
rtl/mbox_read_return.sv
rtl/mbox_top.sv
tb/mbox_sram_model.sv
tb/mbox_tb.sv

//--- tb/mbox_tb.sv
`timescale 1ns/1ns
// Mailbox controller testbench
// APB scenarios for lock handoff, SRAM data path, ECC and release zeroization
module mbox_tb
    import mbox_pkg::*;
();

    localparam mbox_user_t ROOT_ID      = 32'h0000_0001;
    localparam mbox_user_t SOC_ID       = 32'h0000_0011;
    localparam mbox_user_t BAD_ID       = 32'h0000_0055;
    localparam int         APB_TIMEOUT  = 8;
    localparam int         LOCK_POLLS   = 200;
    localparam logic [31:0] LFSR_SEED   = 32'hfe1d9850;

    logic                            clk;
    logic                            rst_b;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    mbox_paddr_t                     paddr;
    mbox_data_t                      pwdata;
    mbox_user_t                      pauser;
    logic                            pready;
    mbox_data_t                      prdata;
    logic                            pslverr;
    mbox_user_t                      root_user;
    mbox_user_t [MBOX_NUM_USERS-1:0] valid_users;
    logic                            sram_cs;
    logic                            sram_we;
    mbox_sram_addr_t                 sram_addr;
    mbox_data_t                      sram_wdata;
    mbox_ecc_t                       sram_wecc;
    mbox_data_t                      sram_rdata;
    mbox_ecc_t                       sram_recc;
    logic                            soc_req_locked;
    logic                            root_data_avail;
    logic                            soc_data_avail;
    logic                            ecc_single;
    logic                            ecc_double;

    // Response of the last APB transfer
    mbox_data_t  rsp_data;
    logic        rsp_err;
    logic        rsp_ecc_single;
    logic        rsp_ecc_double;
    int          rsp_waits;
    logic [31:0] lfsr_state;

    mbox_top mbox_top_i (
        .clk             (clk),
        .rst_b           (rst_b),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .pauser          (pauser),
        .pready          (pready),
        .prdata          (prdata),
        .pslverr         (pslverr),
        .root_user       (root_user),
        .valid_users     (valid_users),
        .sram_cs         (sram_cs),
        .sram_we         (sram_we),
        .sram_addr       (sram_addr),
        .sram_wdata      (sram_wdata),
        .sram_wecc       (sram_wecc),
        .sram_rdata      (sram_rdata),
        .sram_recc       (sram_recc),
        .soc_req_locked  (soc_req_locked),
        .root_data_avail (root_data_avail),
        .soc_data_avail  (soc_data_avail),
        .ecc_single      (ecc_single),
        .ecc_double      (ecc_double)
    );

    mbox_sram_model sram_i (
        .clk   (clk),
        .cs    (sram_cs),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .wecc  (sram_wecc),
        .rdata (sram_rdata),
        .recc  (sram_recc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting and checks

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_now($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // Only an SRAM read waits, its read goes out in the first access cycle
    assert property (@(posedge clk) disable iff (!rst_b)
                     (psel && penable && !pready) |-> (sram_cs && !sram_we) ##1 pready)
        else fail_now("A wait state came without an SRAM read or lasted too long");

    // Outputs quiet in the first cycle out of reset
    assert property (@(posedge clk)
                     $rose(rst_b) |-> !(pready || pslverr || sram_cs || ecc_single ||
                                        ecc_double || soc_req_locked))
        else fail_now("An output was not 0 after reset");

    ////////////////////////////////////////////////////////////////////////////
    // Random data

    // Galois step, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output mbox_data_t w);
        for (int i = 0; i < 32; i++) begin
            w[i]       = lfsr_state[0];
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB access

    function automatic mbox_paddr_t word_addr(input int word);
        return mbox_paddr_t'(MBOX_SRAM_BASE + 4 * word);
    endfunction

    // Setup then access, inputs change on the falling edge only
    task automatic apb_access(input logic wr, input mbox_paddr_t addr,
                              input mbox_data_t data, input mbox_user_t user);
        int waits;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        pauser  = user;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        #1;
        while (!pready && waits < APB_TIMEOUT) begin
            @(negedge clk);
            #1;
            waits++;
        end
        if (!pready) begin
            fail_now("APB transfer did not complete in time");
        end
        // Sampled mid-cycle, before the completing edge
        rsp_data       = prdata;
        rsp_err        = pslverr;
        rsp_ecc_single = ecc_single;
        rsp_ecc_double = ecc_double;
        rsp_waits      = waits;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_ok(input mbox_paddr_t addr, input mbox_data_t data,
                            input mbox_user_t user);
        apb_access(1'b1, addr, data, user);
        check_equal("pslverr", rsp_err, 1'b0);
        check_equal("write wait states", rsp_waits, 0);
    endtask

    task automatic expect_read(input mbox_paddr_t addr, input mbox_user_t user,
                               input mbox_data_t exp, input string name);
        apb_access(1'b0, addr, '0, user);
        check_equal("pslverr", rsp_err, 1'b0);
        check_equal("register read wait states", rsp_waits, 0);
        check_equal(name, rsp_data, exp);
    endtask

    // Rejected in the first access cycle
    task automatic expect_error(input logic wr, input mbox_paddr_t addr,
                                input mbox_user_t user);
        apb_access(wr, addr, 32'hDEAD_BEEF, user);
        check_equal("pslverr", rsp_err, 1'b1);
        check_equal("error wait states", rsp_waits, 0);
    endtask

    // Clean SRAM read, one wait state
    task automatic check_sram_word(input int word, input mbox_data_t exp);
        apb_access(1'b0, word_addr(word), '0, SOC_ID);
        check_equal("pslverr", rsp_err, 1'b0);
        check_equal("SRAM read wait states", rsp_waits, 1);
        check_equal($sformatf("SRAM word %0d", word), rsp_data, exp);
        check_equal("ecc_single", rsp_ecc_single, 1'b0);
        check_equal("ecc_double", rsp_ecc_double, 1'b0);
    endtask

    // Poll LOCK until a read returns 0 and so takes the lock
    task automatic acquire_lock(input mbox_user_t user);
        int polls;
        polls = 0;
        apb_access(1'b0, MBOX_LOCK_OFS, '0, user);
        while (rsp_data[0] !== 1'b0 && polls < LOCK_POLLS) begin
            apb_access(1'b0, MBOX_LOCK_OFS, '0, user);
            polls++;
        end
        if (rsp_data[0] !== 1'b0) begin
            fail_now("Lock was never freed after release");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Scenarios

    initial begin : stimulus
        mbox_data_t words [6];
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        pauser      = '0;
        root_user   = ROOT_ID;
        valid_users = {32'h14, 32'h13, 32'h12, 32'h11, 32'h10};
        lfsr_state  = LFSR_SEED;
        rst_b       = 1'b0;
        repeat (3) @(negedge clk);
        rst_b = 1'b1;

        // Root owns the lock out of reset
        expect_read(MBOX_LOCK_OFS, ROOT_ID, 32'd1, "LOCK");
        expect_read(MBOX_USER_OFS, ROOT_ID, ROOT_ID, "USER");
        write_ok(MBOX_CMD_OFS, 32'h0000_00A5, ROOT_ID);
        expect_read(MBOX_LOCK_OFS, SOC_ID, 32'd1, "LOCK");
        check_equal("soc_req_locked", soc_req_locked, 1'b1);
        @(negedge clk);
        check_equal("soc_req_locked", soc_req_locked, 1'b0);
        expect_error(1'b1, MBOX_CMD_OFS, SOC_ID);
        expect_read(MBOX_CMD_OFS, ROOT_ID, 32'h0000_00A5, "CMD");

        // Root hands the mailbox over
        write_ok(MBOX_EXECUTE_OFS, 32'd0, ROOT_ID);
        acquire_lock(SOC_ID);
        expect_read(MBOX_USER_OFS, SOC_ID, SOC_ID, "USER");
        expect_read(MBOX_LOCK_OFS, SOC_ID, 32'd1, "LOCK");

        // Owner fills the mailbox
        for (int i = 0; i < 6; i++) begin
            random_word(words[i]);
            write_ok(word_addr(i), words[i], SOC_ID);
        end
        write_ok(MBOX_DLEN_OFS, 32'd20, SOC_ID);
        write_ok(MBOX_CMD_OFS, 32'h0000_1234, SOC_ID);
        write_ok(MBOX_STATUS_OFS, 32'h0000_0077, SOC_ID);
        write_ok(MBOX_EXECUTE_OFS, 32'd1, SOC_ID);
        check_equal("soc_data_avail", soc_data_avail, 1'b1);
        check_equal("root_data_avail", root_data_avail, 1'b0);
        for (int i = 0; i < 6; i++) begin
            check_sram_word(i, words[i]);
        end
        expect_error(1'b0, word_addr(0), BAD_ID);
        expect_error(1'b0, mbox_paddr_t'(MBOX_SRAM_BASE + MBOX_SRAM_BYTES), SOC_ID);

        // Single flip is corrected
        sram_i.flip_bit(8'd2, 7);
        apb_access(1'b0, word_addr(2), '0, SOC_ID);
        check_equal("SRAM word 2", rsp_data, words[2]);
        check_equal("SRAM read wait states", rsp_waits, 1);
        check_equal("ecc_single", rsp_ecc_single, 1'b1);
        check_equal("ecc_double", rsp_ecc_double, 1'b0);
        check_equal("ecc_single", ecc_single, 1'b0);

        // Second flip in the same word is detected
        sram_i.flip_bit(8'd2, 20);
        apb_access(1'b0, word_addr(2), '0, SOC_ID);
        check_equal("ecc_double", rsp_ecc_double, 1'b1);
        check_equal("ecc_single", rsp_ecc_single, 1'b0);
        check_equal("prdata", rsp_data, 32'd0);

        // Release clears words 0..4, word 5 lies past DLEN
        write_ok(MBOX_EXECUTE_OFS, 32'd0, SOC_ID);
        check_equal("soc_data_avail", soc_data_avail, 1'b0);
        acquire_lock(SOC_ID);
        for (int i = 0; i < 5; i++) begin
            check_sram_word(i, 32'd0);
        end
        check_sram_word(5, words[5]);
        expect_read(MBOX_CMD_OFS, SOC_ID, 32'd0, "CMD");
        expect_read(MBOX_DLEN_OFS, SOC_ID, 32'd0, "DLEN");
        expect_read(MBOX_STATUS_OFS, SOC_ID, 32'd0, "CMD_STATUS");

        $display("** PASS **");
        $finish;
    end

endmodule

//--- tb/mbox_sram_model.sv
`timescale 1ns/1ns
// Behavioral mailbox SRAM
// One-cycle read latency, data stored with its check bits, bit flips injected by the testbench
module mbox_sram_model
    import mbox_pkg::*;
(
    input  logic            clk,
    input  logic            cs,
    input  logic            we,
    input  mbox_sram_addr_t addr,
    input  mbox_data_t      wdata,
    input  mbox_ecc_t       wecc,
    output mbox_data_t      rdata,
    output mbox_ecc_t       recc
);

    // Each entry is {check bits, data}
    logic [38:0] mem [MBOX_SRAM_DEPTH];

    // All-zero word is a valid codeword
    initial begin
        for (int i = 0; i < MBOX_SRAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Write stores the word, read returns it on the next cycle
    always @(posedge clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= {wecc, wdata};
            end else begin
                {recc, rdata} <= mem[addr];
            end
        end
    end

    // Invert one stored bit, positions 0..31 are data, 32..38 check bits
    task automatic flip_bit(input mbox_sram_addr_t word, input int pos);
        mem[word][pos] = ~mem[word][pos];
    endtask

endmodule

//--- rtl/mbox_top.sv
`timescale 1ns/1ns
// Mailbox controller top
// APB slave in front of a single ECC-protected SRAM with lock and release control
module mbox_top
    import mbox_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_b,
    // APB slave
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  mbox_paddr_t                     paddr,
    input  mbox_data_t                      pwdata,
    input  mbox_user_t                      pauser,
    output logic                            pready,
    output mbox_data_t                      prdata,
    output logic                            pslverr,
    // Straps
    input  mbox_user_t                      root_user,
    input  mbox_user_t [MBOX_NUM_USERS-1:0] valid_users,
    // SRAM port
    output logic                            sram_cs,
    output logic                            sram_we,
    output mbox_sram_addr_t                 sram_addr,
    output mbox_data_t                      sram_wdata,
    output mbox_ecc_t                       sram_wecc,
    input  mbox_data_t                      sram_rdata,
    input  mbox_ecc_t                       sram_recc,
    // Status to the system
    output logic                            soc_req_locked,
    output logic                            root_data_avail,
    output logic                            soc_data_avail,
    output logic                            ecc_single,
    output logic                            ecc_double
);

    // Decode to execute and result
    mbox_reg_e       reg_sel;
    logic            reg_wr;
    logic            reg_rd;
    logic            sram_req_cs;
    logic            sram_req_we;
    mbox_sram_addr_t sram_req_addr;
    logic            sram_rd_done;
    logic            access_err;

    // Execute and zeroize
    logic            lock_set;
    mbox_user_t      owner;
    mbox_data_t      reg_rdata;
    logic            release_pulse;
    mbox_dlen_t      max_dlen;
    logic            zero_busy;
    logic            zero_done;

    mbox_access_decode mbox_access_decode_i (
        .clk           (clk),
        .rst_b         (rst_b),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pauser        (pauser),
        .root_user     (root_user),
        .valid_users   (valid_users),
        .lock_set      (lock_set),
        .owner         (owner),
        .reg_sel       (reg_sel),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .sram_req_cs   (sram_req_cs),
        .sram_req_we   (sram_req_we),
        .sram_req_addr (sram_req_addr),
        .sram_rd_done  (sram_rd_done),
        .access_err    (access_err)
    );

    mbox_lock_regs mbox_lock_regs_i (
        .clk             (clk),
        .rst_b           (rst_b),
        .reg_sel         (reg_sel),
        .reg_wr          (reg_wr),
        .reg_rd          (reg_rd),
        .pwdata          (pwdata),
        .pauser          (pauser),
        .root_user       (root_user),
        .zero_busy       (zero_busy),
        .zero_done       (zero_done),
        .lock_set        (lock_set),
        .owner           (owner),
        .reg_rdata       (reg_rdata),
        .release_pulse   (release_pulse),
        .max_dlen        (max_dlen),
        .soc_req_locked  (soc_req_locked),
        .root_data_avail (root_data_avail),
        .soc_data_avail  (soc_data_avail)
    );

    mbox_sram_zeroize mbox_sram_zeroize_i (
        .clk           (clk),
        .rst_b         (rst_b),
        .release_pulse (release_pulse),
        .max_dlen      (max_dlen),
        .sram_req_cs   (sram_req_cs),
        .sram_req_we   (sram_req_we),
        .sram_req_addr (sram_req_addr),
        .pwdata        (pwdata),
        .sram_cs       (sram_cs),
        .sram_we       (sram_we),
        .sram_addr     (sram_addr),
        .sram_wdata    (sram_wdata),
        .sram_wecc     (sram_wecc),
        .zero_busy     (zero_busy),
        .zero_done     (zero_done)
    );

    mbox_read_return mbox_read_return_i (
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .reg_rd       (reg_rd),
        .sram_rd_done (sram_rd_done),
        .access_err   (access_err),
        .reg_rdata    (reg_rdata),
        .sram_rdata   (sram_rdata),
        .sram_recc    (sram_recc),
        .pready       (pready),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .ecc_single   (ecc_single),
        .ecc_double   (ecc_double)
    );

endmodule

//--- rtl/mbox_read_return.sv
`timescale 1ns/1ns
// Mailbox read return
// ECC check and correction of SRAM data, read data select, APB ready and error
module mbox_read_return
    import mbox_pkg::*;
(
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic       reg_rd,
    input  logic       sram_rd_done,
    input  logic       access_err,
    input  mbox_data_t reg_rdata,
    input  mbox_data_t sram_rdata,
    input  mbox_ecc_t  sram_recc,
    output logic       pready,
    output mbox_data_t prdata,
    output logic       pslverr,
    output logic       ecc_single,
    output logic       ecc_double
);

    mbox_ecc_t  syndrome;
    mbox_data_t rdata_fixed;
    logic       access;

    ////////////////////////////////////////////////////////////////////////////
    // SRAM read ECC
    assign syndrome = mbox_ecc_syndrome(sram_rdata, sram_recc);

    // Flip the data bit at the failing code position
    always_comb begin : ecc_fix
        int j;
        rdata_fixed = sram_rdata;
        j           = 0;
        for (int pos = 3; pos < 39; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                if (syndrome[6] && syndrome[5:0] == pos[5:0]) begin
                    rdata_fixed[j] = ~sram_rdata[j];
                end
                j++;
            end
        end
    end

    // Odd error count is single and correctable
    // even and nonzero is double
    assign ecc_single = sram_rd_done & syndrome[6];
    assign ecc_double = sram_rd_done & ~syndrome[6] & (syndrome[5:0] != '0);

    ////////////////////////////////////////////////////////////////////////////
    // APB response
    assign access  = psel & penable;
    // Only the first cycle of an SRAM read waits
    assign pready  = access & (pwrite | reg_rd | access_err | sram_rd_done);
    assign pslverr = access & access_err;

    // Uncorrectable data is not returned
    always_comb begin
        if (sram_rd_done) begin
            prdata = ecc_double ? '0 : rdata_fixed;
        end else if (reg_rd) begin
            prdata = reg_rdata;
        end else begin
            prdata = '0;
        end
    end

endmodule

//--- rtl/mbox_sram_zeroize.sv
`timescale 1ns/1ns
// Mailbox SRAM zeroize and write path
// Clears the used SRAM words on release, otherwise passes APB requests with ECC
module mbox_sram_zeroize
    import mbox_pkg::*;
(
    input  logic            clk,
    input  logic            rst_b,
    input  logic            release_pulse,
    input  mbox_dlen_t      max_dlen,
    input  logic            sram_req_cs,
    input  logic            sram_req_we,
    input  mbox_sram_addr_t sram_req_addr,
    input  mbox_data_t      pwdata,
    output logic            sram_cs,
    output logic            sram_we,
    output mbox_sram_addr_t sram_addr,
    output mbox_data_t      sram_wdata,
    output mbox_ecc_t       sram_wecc,
    output logic            zero_busy,
    output logic            zero_done
);

    mbox_zero_e      state;
    mbox_sram_addr_t word_cnt;
    mbox_sram_addr_t end_word;
    mbox_dlen_t      end_byte;
    logic            running;

    // Last word to clear, word 0 at least, never past the array
    assign end_byte = max_dlen - 1'b1;

    always_comb begin
        if (max_dlen == '0) begin
            end_word = '0;
        end else if (max_dlen > MBOX_SRAM_BYTES) begin
            end_word = mbox_sram_addr_t'(MBOX_SRAM_DEPTH - 1);
        end else begin
            end_word = end_byte[MBOX_BYTE_ADDR_W-1:2];
        end
    end

    assign running   = (state == ZERO_RUN);
    assign zero_busy = running;
    assign zero_done = running & (word_cnt == end_word);

    // One word per cycle from word 0
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state    <= ZERO_IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                ZERO_IDLE: begin
                    if (release_pulse) begin
                        state    <= ZERO_RUN;
                        word_cnt <= '0;
                    end
                end
                ZERO_RUN: begin
                    if (zero_done) begin
                        state <= ZERO_IDLE;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                default: state <= ZERO_IDLE;
            endcase
        end
    end

    // SRAM port mux, clear has the port while running
    assign sram_cs    = running | sram_req_cs;
    assign sram_we    = running | sram_req_we;
    assign sram_addr  = running ? word_cnt : sram_req_addr;
    // Write data only driven for an APB write
    assign sram_wdata = (running || !sram_req_we) ? '0 : pwdata;
    assign sram_wecc  = mbox_ecc_encode(sram_wdata);

endmodule

//--- rtl/mbox_lock_regs.sv
`timescale 1ns/1ns
// Mailbox lock and registers
// Lock ownership, CMD/DLEN/EXECUTE/CMD_STATUS, release detection and status outputs
module mbox_lock_regs
    import mbox_pkg::*;
(
    input  logic       clk,
    input  logic       rst_b,
    input  mbox_reg_e  reg_sel,
    input  logic       reg_wr,
    input  logic       reg_rd,
    input  mbox_data_t pwdata,
    input  mbox_user_t pauser,
    input  mbox_user_t root_user,
    input  logic       zero_busy,
    input  logic       zero_done,
    output logic       lock_set,
    output mbox_user_t owner,
    output mbox_data_t reg_rdata,
    output logic       release_pulse,
    output mbox_dlen_t max_dlen,
    output logic       soc_req_locked,
    output logic       root_data_avail,
    output logic       soc_data_avail
);

    logic       rst_lock_req;
    logic       lock_bit;
    mbox_user_t owner_q;
    mbox_data_t cmd;
    mbox_dlen_t dlen;
    logic       execute;
    mbox_data_t cmd_status;
    logic       lock_rd;
    logic       owner_is_root;

    ////////////////////////////////////////////////////////////////////////////
    // Lock and owner

    // High for the first cycle out of reset, root takes the lock
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rst_lock_req <= 1'b1;
        end else begin
            rst_lock_req <= 1'b0;
        end
    end

    assign owner    = rst_lock_req ? root_user : owner_q;
    // Registers stay closed while the SRAM clears
    assign lock_set = lock_bit & ~zero_busy;
    assign lock_rd  = reg_rd & (reg_sel == MBOX_REG_LOCK);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_bit <= 1'b1;
            owner_q  <= '0;
        end else begin
            // Read of a free lock takes it
            if (rst_lock_req) begin
                owner_q <= root_user;
            end else if (lock_rd && !lock_bit) begin
                owner_q <= pauser;
            end else if (release_pulse) begin
                owner_q <= '0;
            end
            // Lock held until the clear has finished
            if (zero_done) begin
                lock_bit <= 1'b0;
            end else if (lock_rd) begin
                lock_bit <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Mailbox registers

    // Writing 0 to EXECUTE hands the mailbox back
    assign release_pulse = reg_wr & (reg_sel == MBOX_REG_EXECUTE) & ~pwdata[0];

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cmd        <= '0;
            dlen       <= '0;
            execute    <= 1'b0;
            cmd_status <= '0;
        end else if (release_pulse) begin
            cmd        <= '0;
            dlen       <= '0;
            execute    <= 1'b0;
            cmd_status <= '0;
        end else if (reg_wr) begin
            case (reg_sel)
                MBOX_REG_CMD:     cmd        <= pwdata;
                MBOX_REG_DLEN:    dlen       <= pwdata;
                MBOX_REG_EXECUTE: execute    <= pwdata[0];
                MBOX_REG_STATUS:  cmd_status <= pwdata;
                default:          ;
            endcase
        end
    end

    // Largest DLEN of this lock bounds the clear
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            max_dlen <= '0;
        end else if (zero_done) begin
            max_dlen <= '0;
        end else if (reg_wr && reg_sel == MBOX_REG_DLEN && pwdata > max_dlen) begin
            max_dlen <= pwdata;
        end
    end

    // Register read mux
    always_comb begin
        case (reg_sel)
            MBOX_REG_LOCK:    reg_rdata = mbox_data_t'(lock_bit);
            MBOX_REG_USER:    reg_rdata = owner;
            MBOX_REG_CMD:     reg_rdata = cmd;
            MBOX_REG_DLEN:    reg_rdata = dlen;
            MBOX_REG_EXECUTE: reg_rdata = mbox_data_t'(execute);
            MBOX_REG_STATUS:  reg_rdata = cmd_status;
            default:          reg_rdata = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Status outputs
    assign owner_is_root = (owner == root_user);

    // SoC asked for the lock while root holds it
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            soc_req_locked <= 1'b0;
        end else begin
            soc_req_locked <= lock_rd & lock_set & owner_is_root & (pauser != root_user);
        end
    end

    assign root_data_avail = execute & owner_is_root;
    assign soc_data_avail  = execute & ~owner_is_root;

endmodule

//--- rtl/mbox_access_decode.sv
`timescale 1ns/1ns
// Mailbox access decode
// Checks requester user and lock ownership, maps each APB access to a register or SRAM
module mbox_access_decode
    import mbox_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_b,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  mbox_paddr_t                     paddr,
    input  mbox_user_t                      pauser,
    input  mbox_user_t                      root_user,
    input  mbox_user_t [MBOX_NUM_USERS-1:0] valid_users,
    input  logic                            lock_set,
    input  mbox_user_t                      owner,
    output mbox_reg_e                       reg_sel,
    output logic                            reg_wr,
    output logic                            reg_rd,
    output logic                            sram_req_cs,
    output logic                            sram_req_we,
    output mbox_sram_addr_t                 sram_req_addr,
    output logic                            sram_rd_done,
    output logic                            access_err
);

    logic        rd_pend;
    logic        first_access;
    logic        user_valid;
    logic        is_root;
    logic        has_perm;
    logic        in_sram;
    logic        sram_in_range;
    mbox_paddr_t sram_ofs;

    // Second access cycle of an SRAM read carries no new request
    assign first_access = psel & penable & ~rd_pend;

    ////////////////////////////////////////////////////////////////////////////
    // Requester checks

    // Strap users, default user and root are all valid
    always_comb begin
        user_valid = (pauser == MBOX_DEF_USER) | is_root;
        for (int i = 0; i < MBOX_NUM_USERS; i++) begin
            user_valid |= (pauser == valid_users[i]);
        end
    end

    assign is_root  = (pauser == root_user);
    // Owner or root, and only while the lock is held and not clearing
    assign has_perm = lock_set & (is_root | (pauser == owner));

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    assign in_sram       = (paddr >= MBOX_SRAM_BASE);
    assign sram_in_range = (paddr < MBOX_SRAM_BASE + MBOX_SRAM_BYTES);
    assign sram_ofs      = paddr - MBOX_SRAM_BASE;
    assign sram_req_addr = sram_ofs[MBOX_BYTE_ADDR_W-1:2];

    always_comb begin
        reg_sel = MBOX_REG_NONE;
        if (!in_sram) begin
            case (paddr)
                MBOX_LOCK_OFS:    reg_sel = MBOX_REG_LOCK;
                MBOX_USER_OFS:    reg_sel = MBOX_REG_USER;
                MBOX_CMD_OFS:     reg_sel = MBOX_REG_CMD;
                MBOX_DLEN_OFS:    reg_sel = MBOX_REG_DLEN;
                MBOX_EXECUTE_OFS: reg_sel = MBOX_REG_EXECUTE;
                MBOX_STATUS_OFS:  reg_sel = MBOX_REG_STATUS;
                default:          reg_sel = MBOX_REG_NONE;
            endcase
        end
    end

    // Register reads need no lock, SRAM accesses and register writes do
    assign access_err = first_access &
                        (~user_valid |
                         (in_sram & (~sram_in_range | ~has_perm)) |
                         (~in_sram & ((reg_sel == MBOX_REG_NONE) | (pwrite & ~has_perm))));

    // Accepted register strobes
    assign reg_wr = first_access & ~access_err & ~in_sram & pwrite;
    assign reg_rd = first_access & ~access_err & ~in_sram & ~pwrite;

    // Accepted SRAM request, one per access
    assign sram_req_cs = first_access & ~access_err & in_sram;
    assign sram_req_we = sram_req_cs & pwrite;

    // Read data returns one cycle after the request
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= sram_req_cs & ~pwrite;
        end
    end

    assign sram_rd_done = rd_pend;

endmodule

//--- rtl/mbox_pkg.sv
// Mailbox shared definitions
// Widths, SRAM geometry, register map, FSM encodings and the SRAM ECC code
package mbox_pkg;

    // Data types with a meaning
    typedef logic [31:0] mbox_user_t;
    typedef logic [15:0] mbox_paddr_t;
    typedef logic [31:0] mbox_data_t;
    typedef logic [6:0]  mbox_ecc_t;
    typedef logic [7:0]  mbox_sram_addr_t;
    typedef logic [31:0] mbox_dlen_t;

    // SRAM geometry, 32-bit words
    localparam int MBOX_SRAM_BYTES  = 1024;
    localparam int MBOX_SRAM_DEPTH  = MBOX_SRAM_BYTES / 4;
    localparam int MBOX_BYTE_ADDR_W = $clog2(MBOX_SRAM_BYTES);

    // Requester users
    localparam int         MBOX_NUM_USERS = 5;
    localparam mbox_user_t MBOX_DEF_USER  = 32'hFFFF_FFFF;

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    localparam mbox_paddr_t MBOX_SRAM_BASE   = 16'h8000;
    localparam mbox_paddr_t MBOX_LOCK_OFS    = 16'h0000;
    localparam mbox_paddr_t MBOX_USER_OFS    = 16'h0004;
    localparam mbox_paddr_t MBOX_CMD_OFS     = 16'h0008;
    localparam mbox_paddr_t MBOX_DLEN_OFS    = 16'h000C;
    localparam mbox_paddr_t MBOX_EXECUTE_OFS = 16'h0010;
    localparam mbox_paddr_t MBOX_STATUS_OFS  = 16'h0014;

    typedef enum logic [2:0] {
        MBOX_REG_NONE,
        MBOX_REG_LOCK,
        MBOX_REG_USER,
        MBOX_REG_CMD,
        MBOX_REG_DLEN,
        MBOX_REG_EXECUTE,
        MBOX_REG_STATUS
    } mbox_reg_e;

    // Release-time SRAM clear
    typedef enum logic {
        ZERO_IDLE,
        ZERO_RUN
    } mbox_zero_e;

    ////////////////////////////////////////////////////////////////////////////
    // Hamming SEC-DED, 32 data bits and 7 check bits
    // Data sits on the code positions 3..38 that are not powers of two
    // Bit 6 is overall parity over data and the six Hamming bits
    function automatic mbox_ecc_t mbox_ecc_encode(input mbox_data_t data);
        mbox_ecc_t ecc;
        int        j;
        ecc = '0;
        j   = 0;
        for (int pos = 3; pos < 39; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                for (int k = 0; k < 6; k++) begin
                    if (pos[k]) begin
                        ecc[k] ^= data[j];
                    end
                end
                j++;
            end
        end
        ecc[6] = ^{data, ecc[5:0]};
        return ecc;
    endfunction

    // Low six bits give the failing position, bit 6 is set on odd error count
    function automatic mbox_ecc_t mbox_ecc_syndrome(input mbox_data_t data,
                                                    input mbox_ecc_t  ecc);
        mbox_ecc_t syn;
        syn    = mbox_ecc_encode(data) ^ ecc;
        syn[6] = ^{data, ecc};
        return syn;
    endfunction

endpackage
